//--- cpu_macros.svh
// width, opcode and ALU select constants for the 16-bit pipeline; include where needed
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path and register file
`define CPU_WORD_W     16
`define CPU_REG_COUNT  8
`define CPU_REG_IDX_W  3
`define CPU_OPC_W      5
`define CPU_ALU_SEL_W  2

// PC counts bytes, one instruction is two bytes
`define CPU_PC_STEP    2
`define CPU_RESET_PC   0

// opcodes, instruction bits 15 to 11
`define OPC_HALT       5'b00000
`define OPC_NOP        5'b00001
`define OPC_ADDI       5'b01000
`define OPC_SUBI       5'b01001
`define OPC_XORI       5'b01010
`define OPC_ANDNI      5'b01011
`define OPC_LBI        5'b11000
`define OPC_ALU_R      5'b11011

// ALU selects, same encoding as the R-format function field
`define ALU_ADD        2'b00
`define ALU_SUB        2'b01
`define ALU_XOR        2'b10
`define ALU_ANDN       2'b11

`endif

//--- cpu_pkg.sv
// shared types and pipeline register structs; imported by every RTL module of the core
`include "cpu_macros.svh"

package cpu_pkg;

   typedef logic [`CPU_WORD_W-1:0]    word_t;
   typedef logic [`CPU_WORD_W-1:0]    instr_t;
   typedef logic [`CPU_WORD_W-1:0]    pc_t;
   typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;
   typedef logic [`CPU_OPC_W-1:0]     opcode_t;
   typedef logic [`CPU_ALU_SEL_W-1:0] alu_sel_t;

   typedef enum logic [0:0] {
      FETCH_RUN,
      FETCH_HALTED
   } fetch_state_e;

   // fetch to decode
   typedef struct packed {
      logic   valid;
      instr_t instr;
   } if_id_t;

   // decode to execute
   typedef struct packed {
      logic     valid;
      logic     wr_en;
      reg_idx_t rd;
      reg_idx_t rs;
      reg_idx_t rt;
      word_t    op_a;
      word_t    op_b;
      word_t    imm;
      logic     use_imm;
      // low for LBI, operand A is a forced zero
      logic     use_rs;
      // swapped operand order: SUBI and R-format sub
      logic     imm_minus_rs;
      alu_sel_t alu_sel;
      logic     halt;
      logic     bad_op;
   } id_ex_t;

   // execute to write-back, also the forwarding source
   typedef struct packed {
      logic     valid;
      logic     wr_en;
      reg_idx_t rd;
      word_t    data;
      logic     halt;
      logic     bad_op;
   } ex_wb_t;

   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      word_t    data;
   } retire_t;

endpackage

//--- fetch_unit.sv
// fetch stage; holds the PC, addresses instruction memory and fills the fetch/decode register
`include "cpu_macros.svh"

module fetch_unit
   import cpu_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   halt_req,
   output pc_t    imem_addr,
   input  instr_t imem_data,
   output if_id_t if_id
);

   fetch_state_e state_q;
   pc_t          pc_q;

   // memory answers combinationally for the current PC
   assign imem_addr = pc_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= FETCH_RUN;
         pc_q    <= pc_t'(`CPU_RESET_PC);
         if_id   <= '0;
      end else begin
         case (state_q)
            FETCH_RUN: begin
               if (halt_req) begin
                  // word fetched behind the halt is dropped, PC stays put
                  state_q     <= FETCH_HALTED;
                  if_id.valid <= 1'b0;
               end else begin
                  pc_q        <= pc_q + pc_t'(`CPU_PC_STEP);
                  if_id.valid <= 1'b1;
                  if_id.instr <= imem_data;
               end
            end
            FETCH_HALTED: begin
               // only reset leaves this state
               if_id.valid <= 1'b0;
            end
            default: begin
               state_q     <= FETCH_HALTED;
               if_id.valid <= 1'b0;
            end
         endcase
      end
   end

endmodule

//--- reg_file.sv
// eight-entry register file, two read ports and one write port with write-to-read bypass
`include "cpu_macros.svh"

module reg_file
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t rd_idx_a,
   input  reg_idx_t rd_idx_b,
   output word_t    rd_data_a,
   output word_t    rd_data_b,
   input  logic     wr_en,
   input  reg_idx_t wr_idx,
   input  word_t    wr_data
);

   word_t regs_q [`CPU_REG_COUNT];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_en) begin
         regs_q[wr_idx] <= wr_data;
      end
   end

   // bypass covers the producer two ahead of the reader
   assign rd_data_a = (wr_en && (wr_idx == rd_idx_a)) ? wr_data : regs_q[rd_idx_a];
   assign rd_data_b = (wr_en && (wr_idx == rd_idx_b)) ? wr_data : regs_q[rd_idx_b];

endmodule

//--- decode_unit.sv
// decode stage; turns the opcode into controls, reads registers and fills the decode/execute register
`include "cpu_macros.svh"

module decode_unit
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  if_id_t   if_id,
   output logic     halt_req,
   output reg_idx_t rd_idx_a,
   output reg_idx_t rd_idx_b,
   input  word_t    rd_data_a,
   input  word_t    rd_data_b,
   output id_ex_t   id_ex
);

   opcode_t  opc;
   reg_idx_t rs;
   reg_idx_t rt;
   reg_idx_t rd;
   word_t    imm;
   word_t    imm5_sext;
   word_t    imm5_zext;
   word_t    imm8_sext;
   alu_sel_t alu_sel;
   logic     wr_en;
   logic     use_imm;
   logic     use_rs;
   logic     imm_minus_rs;
   logic     is_halt;
   logic     bad_op;

   assign opc = if_id.instr[`CPU_WORD_W-1 -: `CPU_OPC_W];
   assign rs  = if_id.instr[10:8];
   assign rt  = if_id.instr[7:5];

   assign imm5_sext = {{(`CPU_WORD_W-5){if_id.instr[4]}}, if_id.instr[4:0]};
   assign imm5_zext = {{(`CPU_WORD_W-5){1'b0}}, if_id.instr[4:0]};
   assign imm8_sext = {{(`CPU_WORD_W-8){if_id.instr[7]}}, if_id.instr[7:0]};

   always_comb begin
      wr_en        = 1'b0;
      use_imm      = 1'b0;
      use_rs       = 1'b1;
      imm_minus_rs = 1'b0;
      is_halt      = 1'b0;
      bad_op       = 1'b0;
      alu_sel      = `ALU_ADD;
      rd           = if_id.instr[7:5];
      imm          = imm5_sext;
      case (opc)
         `OPC_HALT: is_halt = 1'b1;
         `OPC_NOP: begin
            // no write and no side effect
         end
         `OPC_ADDI: begin
            wr_en   = 1'b1;
            use_imm = 1'b1;
         end
         `OPC_SUBI: begin
            wr_en        = 1'b1;
            use_imm      = 1'b1;
            imm_minus_rs = 1'b1;
            alu_sel      = `ALU_SUB;
         end
         `OPC_XORI: begin
            wr_en   = 1'b1;
            use_imm = 1'b1;
            imm     = imm5_zext;
            alu_sel = `ALU_XOR;
         end
         `OPC_ANDNI: begin
            wr_en   = 1'b1;
            use_imm = 1'b1;
            imm     = imm5_zext;
            alu_sel = `ALU_ANDN;
         end
         `OPC_LBI: begin
            // 0 + imm8, so the ALU needs no load case
            wr_en   = 1'b1;
            use_imm = 1'b1;
            use_rs  = 1'b0;
            rd      = rs;
            imm     = imm8_sext;
         end
         `OPC_ALU_R: begin
            wr_en        = 1'b1;
            rd           = if_id.instr[4:2];
            alu_sel      = if_id.instr[1:0];
            imm_minus_rs = (if_id.instr[1:0] == `ALU_SUB);
         end
         default: bad_op = 1'b1;
      endcase
   end

   assign rd_idx_a = rs;
   assign rd_idx_b = rt;

   // fetch stops on HALT and on anything it cannot decode
   assign halt_req = if_id.valid & (is_halt | bad_op);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_ex <= '0;
      end else begin
         id_ex.valid        <= if_id.valid;
         id_ex.wr_en        <= wr_en;
         id_ex.rd           <= rd;
         id_ex.rs           <= rs;
         id_ex.rt           <= rt;
         id_ex.op_a         <= use_rs ? rd_data_a : '0;
         id_ex.op_b         <= rd_data_b;
         id_ex.imm          <= imm;
         id_ex.use_imm      <= use_imm;
         id_ex.use_rs       <= use_rs;
         id_ex.imm_minus_rs <= imm_minus_rs;
         id_ex.alu_sel      <= alu_sel;
         id_ex.halt         <= is_halt | bad_op;
         id_ex.bad_op       <= bad_op;
      end
   end

endmodule

//--- execute_unit.sv
// execute stage; forwarding from write-back and the ALU, purely combinational
`include "cpu_macros.svh"

module execute_unit
   import cpu_pkg::*;
(
   input  id_ex_t id_ex,
   input  ex_wb_t wb_fwd,
   output ex_wb_t ex_result
);

   logic  fwd_live;
   logic  fwd_a;
   logic  fwd_b;
   word_t src_a;
   word_t src_b;
   word_t opnd_b;
   word_t alu_x;
   word_t alu_y;
   word_t alu_out;

   // the instruction just ahead sits in the write-back register
   assign fwd_live = wb_fwd.valid & wb_fwd.wr_en;
   assign fwd_a    = fwd_live & id_ex.use_rs & (wb_fwd.rd == id_ex.rs);
   assign fwd_b    = fwd_live & (wb_fwd.rd == id_ex.rt);

   assign src_a = fwd_a ? wb_fwd.data : id_ex.op_a;
   assign src_b = fwd_b ? wb_fwd.data : id_ex.op_b;

   assign opnd_b = id_ex.use_imm ? id_ex.imm : src_b;

   // swapped order gives imm - Rs and Rt - Rs
   assign alu_x = id_ex.imm_minus_rs ? opnd_b : src_a;
   assign alu_y = id_ex.imm_minus_rs ? src_a : opnd_b;

   always_comb begin
      case (id_ex.alu_sel)
         `ALU_ADD:  alu_out = alu_x + alu_y;
         `ALU_SUB:  alu_out = alu_x - alu_y;
         `ALU_XOR:  alu_out = alu_x ^ alu_y;
         `ALU_ANDN: alu_out = alu_x & ~alu_y;
         default:   alu_out = alu_x + alu_y;
      endcase
   end

   always_comb begin
      ex_result.valid  = id_ex.valid;
      ex_result.wr_en  = id_ex.wr_en;
      ex_result.rd     = id_ex.rd;
      ex_result.data   = alu_out;
      ex_result.halt   = id_ex.halt;
      ex_result.bad_op = id_ex.bad_op;
   end

endmodule

//--- writeback_unit.sv
// write-back stage; holds the execute result, writes the register file and reports retirements
module writeback_unit
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  ex_wb_t   ex_result,
   output ex_wb_t   wb_fwd,
   output logic     rf_wr_en,
   output reg_idx_t rf_wr_idx,
   output word_t    rf_wr_data,
   output retire_t  retire,
   output logic     halted,
   output logic     err
);

   ex_wb_t ex_wb_q;
   logic   wb_write;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_wb_q <= '0;
         halted  <= 1'b0;
         err     <= 1'b0;
      end else begin
         ex_wb_q <= ex_result;
         // sticky, rises in the same edge as the halt's slot
         if (ex_result.valid && ex_result.halt) begin
            halted <= 1'b1;
            err    <= err | ex_result.bad_op;
         end
      end
   end

   assign wb_write = ex_wb_q.valid & ex_wb_q.wr_en;

   assign wb_fwd     = ex_wb_q;
   assign rf_wr_en   = wb_write;
   assign rf_wr_idx  = ex_wb_q.rd;
   assign rf_wr_data = ex_wb_q.data;

   assign retire.valid = wb_write;
   assign retire.rd    = ex_wb_q.rd;
   assign retire.data  = ex_wb_q.data;

endmodule

//--- cpu_top.sv
// top level of the four-stage core; wires fetch, decode, register file, execute and write-back
module cpu_top
   import cpu_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   output pc_t     imem_addr,
   input  instr_t  imem_data,
   output retire_t retire,
   output logic    halted,
   output logic    err
);

   logic     halt_req;
   if_id_t   if_id;
   id_ex_t   id_ex;
   ex_wb_t   ex_result;
   ex_wb_t   wb_fwd;
   reg_idx_t rd_idx_a;
   reg_idx_t rd_idx_b;
   word_t    rd_data_a;
   word_t    rd_data_b;
   logic     rf_wr_en;
   reg_idx_t rf_wr_idx;
   word_t    rf_wr_data;

   fetch_unit fetch_unit_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .halt_req  (halt_req),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .if_id     (if_id)
   );

   decode_unit decode_unit_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .if_id     (if_id),
      .halt_req  (halt_req),
      .rd_idx_a  (rd_idx_a),
      .rd_idx_b  (rd_idx_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .id_ex     (id_ex)
   );

   reg_file reg_file_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_idx_a  (rd_idx_a),
      .rd_idx_b  (rd_idx_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .wr_en     (rf_wr_en),
      .wr_idx    (rf_wr_idx),
      .wr_data   (rf_wr_data)
   );

   execute_unit execute_unit_i (
      .id_ex     (id_ex),
      .wb_fwd    (wb_fwd),
      .ex_result (ex_result)
   );

   writeback_unit writeback_unit_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .ex_result  (ex_result),
      .wb_fwd     (wb_fwd),
      .rf_wr_en   (rf_wr_en),
      .rf_wr_idx  (rf_wr_idx),
      .rf_wr_data (rf_wr_data),
      .retire     (retire),
      .halted     (halted),
      .err        (err)
   );

endmodule

//--- tb_checker.sv
// testbench checker; runs the instruction-set model on each program and compares the core's ports
`include "cpu_macros.svh"

module tb_checker
   import cpu_pkg::*;
(
   input logic    clk,
   input logic    rst_n,
   input instr_t  prog [64],
   input pc_t     imem_addr,
   input retire_t retire,
   input logic    halted,
   input logic    err
);
   timeunit 1ns;
   timeprecision 100ps;

   reg_idx_t exp_rd [$];
   word_t    exp_data [$];
   logic     exp_err;
   pc_t      exp_addr;
   logic     halted_seen;
   int       value_errors = 0;
   int       count_errors = 0;

   task automatic check_value(input string name, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
         value_errors++;
      end
   endtask

   // walks the program in order and queues every register write
   task automatic begin_run();
      word_t  mregs [`CPU_REG_COUNT];
      instr_t ins;
      word_t  a;
      word_t  b;
      word_t  s5;
      word_t  z5;
      word_t  val;
      reg_idx_t rd;
      logic   wr;
      logic   stop;
      int     i;
      exp_rd.delete();
      exp_data.delete();
      halted_seen = 1'b0;
      exp_err     = 1'b0;
      stop        = 1'b0;
      i           = 0;
      for (int r = 0; r < `CPU_REG_COUNT; r++) begin
         mregs[r] = '0;
      end
      while (!stop && i < 64) begin
         ins = prog[i];
         a   = mregs[ins[10:8]];
         b   = mregs[ins[7:5]];
         s5  = {{11{ins[4]}}, ins[4:0]};
         z5  = {11'b0, ins[4:0]};
         wr  = 1'b1;
         rd  = ins[7:5];
         val = '0;
         case (ins[15:11])
            `OPC_ADDI:  val = a + s5;
            `OPC_SUBI:  val = s5 - a;
            `OPC_XORI:  val = a ^ z5;
            `OPC_ANDNI: val = a & ~z5;
            `OPC_LBI: begin
               rd  = ins[10:8];
               val = {{8{ins[7]}}, ins[7:0]};
            end
            `OPC_ALU_R: begin
               rd = ins[4:2];
               case (ins[1:0])
                  `ALU_ADD: val = a + b;
                  `ALU_SUB: val = b - a;
                  `ALU_XOR: val = a ^ b;
                  default:  val = a & ~b;
               endcase
            end
            `OPC_NOP: wr = 1'b0;
            `OPC_HALT: begin
               wr   = 1'b0;
               stop = 1'b1;
            end
            default: begin
               wr      = 1'b0;
               stop    = 1'b1;
               exp_err = 1'b1;
            end
         endcase
         if (wr) begin
            mregs[rd] = val;
            exp_rd.push_back(rd);
            exp_data.push_back(val);
         end
         i++;
      end
      // fetch has stepped once past the stopping word
      exp_addr = pc_t'(2 * i);
   endtask

   task automatic close_run();
      if (exp_rd.size() != 0) begin
         $display("%0d expected retirements never appeared", exp_rd.size());
         count_errors++;
         exp_rd.delete();
         exp_data.delete();
      end
   endtask

   task automatic print_counts(input int timeouts);
      $display("errors: %0d wrong values, %0d missing or extra retirements, %0d timeouts",
               value_errors, count_errors, timeouts);
   endtask

   always @(negedge clk) begin
      if (!rst_n) begin
         check_value("retire.valid", 16'(1'b0), 16'(retire.valid));
         check_value("halted", 16'(1'b0), 16'(halted));
         check_value("err", 16'(1'b0), 16'(err));
      end else if (!halted_seen) begin
         if (retire.valid) begin
            if (exp_rd.size() == 0) begin
               $display("extra retirement of r%0d with no write left in the program at %0t",
                        retire.rd, $time);
               count_errors++;
            end else begin
               check_value("retire.rd", 16'(exp_rd.pop_front()), 16'(retire.rd));
               check_value("retire.data", exp_data.pop_front(), retire.data);
            end
         end
         if (halted) begin
            halted_seen = 1'b1;
            check_value("err", 16'(exp_err), 16'(err));
            check_value("imem_addr", exp_addr, imem_addr);
            close_run();
         end else begin
            check_value("err", 16'(1'b0), 16'(err));
         end
      end else begin
         if (retire.valid) begin
            $display("retirement of r%0d after halted rose at %0t", retire.rd, $time);
            count_errors++;
         end
         check_value("halted", 16'(1'b1), 16'(halted));
         check_value("err", 16'(exp_err), 16'(err));
         check_value("imem_addr", exp_addr, imem_addr);
      end
   end

endmodule

//--- tb_top.sv
// testbench top; drives clock, reset and instruction memory, and runs random and directed programs
`include "cpu_macros.svh"

module tb_top
   import cpu_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RUNS        = 10;
   localparam int RUN_TIMEOUT = 200;
   localparam int HOLD_CYCLES = 20;

   logic    clk       = 1'b0;
   logic    rst_n     = 1'b0;
   instr_t  imem_data = '0;
   pc_t     imem_addr;
   retire_t retire;
   logic    halted;
   logic    err;

   instr_t  imem [64];
   integer  seed;
   int      timeouts;

   always #10 clk = ~clk;

   // word address is the byte address over two
   always @(negedge clk) begin
      imem_data <= imem[imem_addr[6:1]];
   end

   cpu_top cpu_top_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .retire    (retire),
      .halted    (halted),
      .err       (err)
   );

   tb_checker checker_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .prog      (imem),
      .imem_addr (imem_addr),
      .retire    (retire),
      .halted    (halted),
      .err       (err)
   );

   function automatic instr_t enc_imm5(opcode_t opc, reg_idx_t rs, reg_idx_t rd, logic [4:0] imm);
      return {opc, rs, rd, imm};
   endfunction

   function automatic instr_t enc_lbi(reg_idx_t rd, logic [7:0] imm);
      return {`OPC_LBI, rd, imm};
   endfunction

   function automatic instr_t enc_alu_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, alu_sel_t func);
      return {`OPC_ALU_R, rs, rt, rd, func};
   endfunction

   // mostly r0 to r3 so that dependences are frequent
   function automatic reg_idx_t pick_reg();
      if (($random(seed) & 3) == 0) begin
         return reg_idx_t'($random(seed));
      end else begin
         return reg_idx_t'($random(seed) & 3);
      end
   endfunction

   function automatic instr_t random_instr();
      int kind;
      kind = $random(seed) & 7;
      case (kind)
         0: return enc_imm5(`OPC_ADDI, pick_reg(), pick_reg(), 5'($random(seed)));
         1: return enc_imm5(`OPC_SUBI, pick_reg(), pick_reg(), 5'($random(seed)));
         2: return enc_imm5(`OPC_XORI, pick_reg(), pick_reg(), 5'($random(seed)));
         3: return enc_imm5(`OPC_ANDNI, pick_reg(), pick_reg(), 5'($random(seed)));
         4: return enc_lbi(pick_reg(), 8'($random(seed)));
         5, 6: return enc_alu_r(pick_reg(), pick_reg(), pick_reg(), 2'($random(seed)));
         default: return {`OPC_NOP, 11'($random(seed))};
      endcase
   endfunction

   task automatic fill_random();
      for (int i = 0; i < 64; i++) begin
         imem[i] = instr_t'($random(seed));
      end
   endtask

   // each step reads the result one or two instructions back
   task automatic load_chain();
      fill_random();
      imem[0] = enc_lbi(3'd1, 8'h7f);
      imem[1] = enc_imm5(`OPC_ADDI, 3'd1, 3'd2, 5'h01);
      imem[2] = enc_alu_r(3'd1, 3'd2, 3'd3, `ALU_ADD);
      imem[3] = enc_imm5(`OPC_SUBI, 3'd3, 3'd3, 5'h1f);
      imem[4] = enc_imm5(`OPC_XORI, 3'd3, 3'd4, 5'h15);
      imem[5] = enc_alu_r(3'd3, 3'd4, 3'd5, `ALU_SUB);
      imem[6] = enc_imm5(`OPC_ANDNI, 3'd5, 3'd5, 5'h03);
      imem[7] = enc_alu_r(3'd5, 3'd4, 3'd6, `ALU_XOR);
      imem[8] = enc_alu_r(3'd6, 3'd5, 3'd1, `ALU_ANDN);
      imem[9] = {`OPC_HALT, 11'h000};
   endtask

   // random words stay behind the last instruction
   task automatic load_random(input logic bad_end);
      int count;
      fill_random();
      count = 4 + ($random(seed) & 31);
      for (int i = 0; i < count; i++) begin
         imem[i] = random_instr();
      end
      if (bad_end) begin
         // opcodes 10xxx are all undefined
         imem[count] = {2'b10, 3'($random(seed)), 11'($random(seed))};
      end else begin
         imem[count] = {`OPC_HALT, 11'($random(seed))};
      end
   endtask

   task automatic run_program();
      int waited;
      @(negedge clk);
      checker_i.begin_run();
      repeat (15) @(negedge clk);
      rst_n <= 1'b1;
      waited = 0;
      while (!halted && waited < RUN_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!halted) begin
         $display("timeout: halted did not rise within %0d cycles", RUN_TIMEOUT);
         timeouts++;
      end else begin
         // fetch must stay frozen while the checker watches
         repeat (HOLD_CYCLES) @(negedge clk);
      end
      checker_i.close_run();
   endtask

   initial begin
      seed     = 32'hf531;
      timeouts = 0;
      fill_random();
      for (int run = 0; run < RUNS; run++) begin
         @(negedge clk);
         rst_n <= 1'b0;
         if (run == 0) begin
            load_chain();
         end else begin
            load_random(run[0]);
         end
         run_program();
      end
      checker_i.print_counts(timeouts);
      if (checker_i.value_errors + checker_i.count_errors + timeouts == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- flist.f
+incdir+.
cpu_pkg.sv
fetch_unit.sv
reg_file.sv
decode_unit.sv
execute_unit.sv
writeback_unit.sv
cpu_top.sv
tb_checker.sv
tb_top.sv

//--- run.sh
#!/bin/sh
# builds the core testbench with Verilator, runs it and judges the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps --top-module tb_top -f flist.f -o tb_sim
./obj_dir/tb_sim > sim.log
cat sim.log
if grep -qF '*** PASSED ***' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
